/* dcache_params.svh */
//##################################################
// cache geometry, checked only at these defaults
// a RAM beat must hold a whole number of words
//##################################################
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// core side
`define DC_ADDR_W 32
`define DC_WORD_W 32
`define DC_WORD_IX_W 3
`define DC_LINE_IX_W 1
// byte offset bits, always zero in a word address
`define DC_ALIGN_W 2

// burst RAM side
`define DC_BEAT_W 64
`define DC_BEATS 4
// 256 beats of 64 bits = 2 KB
`define DC_RAM_DEPTH_W 8

// derived
`define DC_TAG_W (`DC_ADDR_W - `DC_LINE_IX_W - `DC_WORD_IX_W - `DC_ALIGN_W)
`define DC_WORDS_PER_BEAT (`DC_BEAT_W / `DC_WORD_W)
`define DC_LINES (1 << `DC_LINE_IX_W)
`define DC_LINE_WORDS (1 << `DC_WORD_IX_W)

`endif

/* dcache_pkg.sv */
//##################################################
// core-side types of the data cache
// address layout is |tag|line|word|00|
//##################################################
`include "dcache_params.svh"

package dcache_pkg;

  // byte address from the core
  typedef logic [`DC_ADDR_W-1:0] addr_t;

  // upper address bits stored per line
  typedef logic [`DC_TAG_W-1:0] tag_t;

  // line select
  typedef logic [`DC_LINE_IX_W-1:0] line_ix_t;

  // word select within a line
  typedef logic [`DC_WORD_IX_W-1:0] word_ix_t;

  typedef logic [`DC_WORD_W-1:0] word_t;

  // one bit per byte, all zero means read
  typedef logic [`DC_WORD_W/8-1:0] byte_en_t;

  // controller states
  typedef enum logic [2:0] {
    init,
    idle,
    wb_burst,
    fill_wait,
    fill_beats
  } ctrl_state_t;

endpackage

/* burst_ram_pkg.sv */
//##################################################
// burst RAM side types
// one command moves a whole line in DC_BEATS beats
//##################################################
`include "dcache_params.svh"

package burst_ram_pkg;

  // beat address, not byte address
  typedef logic [`DC_RAM_DEPTH_W-1:0] ram_addr_t;

  typedef logic [`DC_BEAT_W-1:0] beat_t;

  typedef logic [`DC_BEAT_W/8-1:0] beat_mask_t;

  // beat position within a burst
  typedef logic [$clog2(`DC_BEATS)-1:0] beat_cnt_t;

  typedef enum logic {
    read  = 1'b0,
    write = 1'b1
  } ram_cmd_t;

endpackage

/* line_store_if.sv */
//##################################################
// controller to line store connection
// all store outputs are combinational reads
//##################################################
`timescale 1ns/1ps

interface line_store_if;

  // lookup position and tag to compare
  dcache_pkg::line_ix_t line_ix;
  dcache_pkg::word_ix_t word_ix;
  dcache_pkg::tag_t req_tag;

  // masked word write
  dcache_pkg::word_t wr_word;
  dcache_pkg::byte_en_t byte_en;
  logic word_wr;

  // refill, one beat of words per cycle
  logic fill_en;
  burst_ram_pkg::beat_cnt_t fill_beat;
  burst_ram_pkg::beat_t fill_data;

  // victim write-back
  burst_ram_pkg::beat_cnt_t drain_beat;
  burst_ram_pkg::beat_t drain_data;

  // new line owner, valid and clean
  logic meta_set;

  // lookup results
  logic hit;
  logic dirty;
  dcache_pkg::tag_t victim_tag;
  dcache_pkg::word_t rd_word;

  modport ctrl (
    output line_ix, word_ix, req_tag, wr_word, byte_en, word_wr,
    output fill_en, fill_beat, fill_data, drain_beat, meta_set,
    input  hit, dirty, victim_tag, rd_word, drain_data
  );

  modport store (
    input  line_ix, word_ix, req_tag, wr_word, byte_en, word_wr,
    input  fill_en, fill_beat, fill_data, drain_beat, meta_set,
    output hit, dirty, victim_tag, rd_word, drain_data
  );

endinterface

/* line_store.sv */
//##################################################
// line storage with tag compare, byte merge and
// beat-wide fill and drain ports, data has no reset
//##################################################
`timescale 1ns/1ps
`include "dcache_params.svh"

module line_store (
  input logic clk,
  input logic rst,
  line_store_if.store bus
);

  // per line state
  logic [`DC_LINES-1:0] valid_q;
  logic [`DC_LINES-1:0] dirty_q;
  dcache_pkg::tag_t tag_q [`DC_LINES];
  dcache_pkg::word_t data_q [`DC_LINES][`DC_LINE_WORDS];

  logic [`DC_BEAT_W-1:0] drain_words;

  // word index of slot i inside beat b
  function automatic dcache_pkg::word_ix_t beat_word(input int unsigned b, input int unsigned i);
    return dcache_pkg::word_ix_t'(b * `DC_WORDS_PER_BEAT + i);
  endfunction

  // lookups
  assign bus.hit = valid_q[bus.line_ix] && (tag_q[bus.line_ix] == bus.req_tag);
  assign bus.dirty = dirty_q[bus.line_ix];
  assign bus.victim_tag = tag_q[bus.line_ix];
  assign bus.rd_word = data_q[bus.line_ix][bus.word_ix];

  // gather one beat of the line for write-back
  always_comb begin
    for (int i = 0; i < `DC_WORDS_PER_BEAT; i++) begin
      drain_words[i*`DC_WORD_W +: `DC_WORD_W] =
        data_q[bus.line_ix][beat_word(bus.drain_beat, i)];
    end
  end

  assign bus.drain_data = drain_words;

  // valid and dirty bits
  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      if (bus.meta_set) begin
        valid_q[bus.line_ix] <= 1'b1;
        dirty_q[bus.line_ix] <= 1'b0;
      end
      // any merged byte makes the line differ from RAM
      if (bus.word_wr) begin
        dirty_q[bus.line_ix] <= 1'b1;
      end
    end
  end

  // tags and line data
  always_ff @(posedge clk) begin
    if (bus.meta_set) begin
      tag_q[bus.line_ix] <= bus.req_tag;
    end
    if (bus.fill_en) begin
      for (int i = 0; i < `DC_WORDS_PER_BEAT; i++) begin
        data_q[bus.line_ix][beat_word(bus.fill_beat, i)] <=
          bus.fill_data[i*`DC_WORD_W +: `DC_WORD_W];
      end
    end
    // byte merge, only enabled lanes change
    if (bus.word_wr) begin
      for (int b = 0; b < `DC_WORD_W / 8; b++) begin
        if (bus.byte_en[b]) begin
          data_q[bus.line_ix][bus.word_ix][b*8 +: 8] <= bus.wr_word[b*8 +: 8];
        end
      end
    end
  end

  // controller defers a miss merge until the refill is over
  a_fill_merge_excl: assert property (
    @(posedge clk) disable iff (rst) !(bus.fill_en && bus.word_wr)
  );

endmodule

/* dcache_ctrl.sv */
//##################################################
// cache FSM, one request at a time, hits take one cycle
// miss = optional 4-beat write-back then 4-beat refill
//##################################################
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_ctrl (
  input  logic clk,
  input  logic rst,
  input  logic enable,
  input  dcache_pkg::addr_t address,
  input  dcache_pkg::byte_en_t write_enable_bytes,
  input  dcache_pkg::word_t data_in,
  output dcache_pkg::word_t data_out,
  output logic data_out_valid,
  output logic busy,
  line_store_if.ctrl store,
  output burst_ram_pkg::ram_cmd_t ram_cmd,
  output logic ram_cmd_en,
  output burst_ram_pkg::ram_addr_t ram_addr,
  output burst_ram_pkg::beat_t ram_wr_data,
  output burst_ram_pkg::beat_mask_t ram_data_mask,
  input  burst_ram_pkg::beat_t ram_rd_data,
  input  logic ram_rd_data_valid,
  input  logic ram_busy
);

  // address field positions
  localparam int word_lsb = `DC_ALIGN_W;
  localparam int line_lsb = word_lsb + `DC_WORD_IX_W;
  localparam int sub_w = $clog2(`DC_WORDS_PER_BEAT);
  // byte address to beat address
  localparam int ram_shift = `DC_ALIGN_W + sub_w;
  localparam int cnt_w = $bits(burst_ram_pkg::beat_cnt_t);
  localparam burst_ram_pkg::beat_cnt_t last_beat = cnt_w'(`DC_BEATS - 1);

  dcache_pkg::ctrl_state_t state_q;
  burst_ram_pkg::beat_cnt_t beat_q;
  // command issued, beats still moving
  logic xfer_q;

  // request held for the whole miss
  dcache_pkg::addr_t req_addr_q;
  dcache_pkg::byte_en_t req_be_q;
  dcache_pkg::word_t req_data_q;

  dcache_pkg::addr_t cur_addr;
  logic in_idle;
  logic accept;
  logic fill_in;
  logic crit_beat;
  logic finish;
  dcache_pkg::word_t crit_word;

  // line base of a tag and line index, as a beat address
  function automatic burst_ram_pkg::ram_addr_t line_base(input dcache_pkg::tag_t t,
                                                         input dcache_pkg::line_ix_t l);
    dcache_pkg::addr_t a;
    a = {t, l, {(`DC_WORD_IX_W + `DC_ALIGN_W){1'b0}}};
    return a[ram_shift +: `DC_RAM_DEPTH_W];
  endfunction

  assign in_idle = (state_q == dcache_pkg::idle);
  assign accept = in_idle && enable && !busy;
  // live request while idle, latched one during a miss
  assign cur_addr = in_idle ? address : req_addr_q;

  assign store.line_ix = cur_addr[line_lsb +: `DC_LINE_IX_W];
  assign store.word_ix = cur_addr[word_lsb +: `DC_WORD_IX_W];
  assign store.req_tag = cur_addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign store.wr_word = in_idle ? data_in : req_data_q;
  assign store.byte_en = in_idle ? write_enable_bytes : req_be_q;

  // one spare cycle after the last refill beat
  assign finish = (state_q == dcache_pkg::fill_beats) && !xfer_q;
  assign store.word_wr = (|store.byte_en) && ((accept && store.hit) || finish);

  // refill path
  assign fill_in = ram_rd_data_valid && xfer_q &&
                   (state_q == dcache_pkg::fill_wait || state_q == dcache_pkg::fill_beats);
  assign store.fill_en = fill_in;
  assign store.fill_beat = beat_q;
  assign store.fill_data = ram_rd_data;
  assign store.drain_beat = beat_q;
  // tag moves over as the read command leaves
  assign store.meta_set = (state_q == dcache_pkg::fill_wait) && !xfer_q && !ram_busy;

  // requested word inside the arriving beat
  assign crit_beat = (cur_addr[word_lsb + sub_w +: cnt_w] == beat_q);
  assign crit_word = ram_rd_data[cur_addr[word_lsb +: sub_w] * `DC_WORD_W +: `DC_WORD_W];

  // full-beat writes only
  assign ram_data_mask = '1;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= dcache_pkg::init;
      busy <= 1'b1;
      data_out_valid <= 1'b0;
      ram_cmd_en <= 1'b0;
      xfer_q <= 1'b0;
      beat_q <= '0;
    end else begin
      data_out_valid <= 1'b0;
      ram_cmd_en <= 1'b0;

      // critical word of a read miss, once per refill
      if (fill_in && crit_beat && req_be_q == '0) begin
        data_out <= crit_word;
        data_out_valid <= 1'b1;
      end

      case (state_q)
        dcache_pkg::init: begin
          if (!ram_busy) begin
            busy <= 1'b0;
            state_q <= dcache_pkg::idle;
          end
        end

        dcache_pkg::idle: begin
          if (accept) begin
            req_addr_q <= address;
            req_be_q <= write_enable_bytes;
            req_data_q <= data_in;
            if (store.hit) begin
              // hit write merges through word_wr
              if (write_enable_bytes == '0) begin
                data_out <= store.rd_word;
                data_out_valid <= 1'b1;
              end
            end else begin
              busy <= 1'b1;
              xfer_q <= 1'b0;
              beat_q <= '0;
              state_q <= store.dirty ? dcache_pkg::wb_burst : dcache_pkg::fill_wait;
            end
          end
        end

        dcache_pkg::wb_burst: begin
          if (!xfer_q) begin
            // beat 0 goes with the command
            if (!ram_busy) begin
              ram_cmd_en <= 1'b1;
              ram_cmd <= burst_ram_pkg::write;
              ram_addr <= line_base(store.victim_tag, store.line_ix);
              ram_wr_data <= store.drain_data;
              beat_q <= beat_q + 1'b1;
              xfer_q <= 1'b1;
            end
          end else begin
            ram_wr_data <= store.drain_data;
            beat_q <= beat_q + 1'b1;
            if (beat_q == last_beat) begin
              xfer_q <= 1'b0;
              state_q <= dcache_pkg::fill_wait;
            end
          end
        end

        dcache_pkg::fill_wait: begin
          if (!xfer_q) begin
            if (!ram_busy) begin
              ram_cmd_en <= 1'b1;
              ram_cmd <= burst_ram_pkg::read;
              ram_addr <= line_base(store.req_tag, store.line_ix);
              beat_q <= '0;
              xfer_q <= 1'b1;
            end
          end else if (fill_in) begin
            // RAM latency varies, first beat ends the wait
            beat_q <= beat_q + 1'b1;
            state_q <= dcache_pkg::fill_beats;
          end
        end

        dcache_pkg::fill_beats: begin
          if (xfer_q) begin
            if (fill_in) begin
              beat_q <= beat_q + 1'b1;
              if (beat_q == last_beat) begin
                xfer_q <= 1'b0;
              end
            end
          end else begin
            // pending write merge lands this cycle
            busy <= 1'b0;
            state_q <= dcache_pkg::idle;
          end
        end

        default: begin
          state_q <= dcache_pkg::init;
        end
      endcase
    end
  end

  // back-to-back commands would overlap two bursts
  a_cmd_pulse: assert property (
    @(posedge clk) disable iff (rst) ram_cmd_en |=> !ram_cmd_en
  );

  // RAM returns data only for our own read command
  a_rd_in_fill: assert property (
    @(posedge clk) disable iff (rst)
    ram_rd_data_valid |-> (state_q == dcache_pkg::fill_wait ||
                           state_q == dcache_pkg::fill_beats)
  );

endmodule

/* data_cache.sv */
//##################################################
// data cache top, core port and burst RAM port
// only beat address bits 7:0 reach the RAM
//##################################################
`timescale 1ns/1ps

module data_cache (
  input  logic clk,
  input  logic rst,
  // core side
  input  logic enable,
  input  dcache_pkg::addr_t address,
  input  dcache_pkg::byte_en_t write_enable_bytes,
  input  dcache_pkg::word_t data_in,
  output dcache_pkg::word_t data_out,
  output logic data_out_valid,
  output logic busy,
  // burst RAM side
  output burst_ram_pkg::ram_cmd_t ram_cmd,
  output logic ram_cmd_en,
  output burst_ram_pkg::ram_addr_t ram_addr,
  output burst_ram_pkg::beat_t ram_wr_data,
  output burst_ram_pkg::beat_mask_t ram_data_mask,
  input  burst_ram_pkg::beat_t ram_rd_data,
  input  logic ram_rd_data_valid,
  input  logic ram_busy
);

  line_store_if store_bus ();

  // FSM owns both ports, store is internal
  dcache_ctrl ctrl0 (
    .clk(clk),
    .rst(rst),
    .enable(enable),
    .address(address),
    .write_enable_bytes(write_enable_bytes),
    .data_in(data_in),
    .data_out(data_out),
    .data_out_valid(data_out_valid),
    .busy(busy),
    .store(store_bus.ctrl),
    .ram_cmd(ram_cmd),
    .ram_cmd_en(ram_cmd_en),
    .ram_addr(ram_addr),
    .ram_wr_data(ram_wr_data),
    .ram_data_mask(ram_data_mask),
    .ram_rd_data(ram_rd_data),
    .ram_rd_data_valid(ram_rd_data_valid),
    .ram_busy(ram_busy)
  );

  line_store store0 (
    .clk(clk),
    .rst(rst),
    .bus(store_bus.store)
  );

endmodule

/* dcache_checker.sv */
//##################################################
// watches the cache ports and keeps a word model of RAM
// addresses must stay below 2 KB to match the RAM
//##################################################
`timescale 1ns/1ps
`include "dcache_params.svh"

module dcache_checker #(
  parameter int preload_seed = 41
) (
  input logic clk,
  input logic rst,
  input logic enable,
  input dcache_pkg::addr_t address,
  input dcache_pkg::byte_en_t write_enable_bytes,
  input dcache_pkg::word_t data_in,
  input dcache_pkg::word_t data_out,
  input logic data_out_valid,
  input logic busy,
  input burst_ram_pkg::ram_cmd_t ram_cmd,
  input logic ram_cmd_en,
  input burst_ram_pkg::ram_addr_t ram_addr,
  input burst_ram_pkg::beat_mask_t ram_data_mask,
  input logic ram_busy,
  output int errors,
  output int pending
);

  localparam int model_words = (1 << `DC_RAM_DEPTH_W) * `DC_WORDS_PER_BEAT;

  // word view of RAM plus every merged write
  dcache_pkg::word_t model [model_words];
  // expected residency of each cache line
  logic valid_m [`DC_LINES];
  logic dirty_m [`DC_LINES];
  dcache_pkg::tag_t tag_m [`DC_LINES];
  dcache_pkg::word_t exp_q [$];
  // {is write, beat address}
  logic [`DC_RAM_DEPTH_W:0] cmd_q [$];
  logic rst_seen = 1'b0;
  logic ram_ready = 1'b0;
  logic hit_due = 1'b0;
  int err_cnt = 0;
  int pend_cnt = 0;
  integer seed;

  assign errors = err_cnt;
  assign pending = pend_cnt;

  // first beat of the line that a tag and line index name
  function automatic burst_ram_pkg::ram_addr_t line_beat(input dcache_pkg::tag_t t,
                                                         input dcache_pkg::line_ix_t l);
    dcache_pkg::addr_t a;
    a = {t, l, {(`DC_WORD_IX_W + `DC_ALIGN_W){1'b0}}};
    return burst_ram_pkg::ram_addr_t'(a / (`DC_BEAT_W / 8));
  endfunction

  // same random pass as the RAM preload with the low word of a beat first
  initial begin
    integer hi;
    integer lo;
    seed = preload_seed;
    for (int i = 0; i < (1 << `DC_RAM_DEPTH_W); i++) begin
      hi = $random(seed);
      lo = $random(seed);
      model[2*i] = lo;
      model[2*i+1] = hi;
    end
  end

  // inputs and outputs are settled at the falling edge
  always @(negedge clk) begin : watch
    dcache_pkg::line_ix_t line;
    dcache_pkg::tag_t tag;
    dcache_pkg::word_t exp;
    logic [`DC_RAM_DEPTH_W:0] cmd;
    logic hit;
    logic due;
    int w;
    due = hit_due;
    hit_due = 1'b0;
    if (rst) begin
      rst_seen = 1'b1;
      for (int l = 0; l < `DC_LINES; l++) begin
        valid_m[l] = 1'b0;
        dirty_m[l] = 1'b0;
      end
      exp_q.delete();
      cmd_q.delete();
    end
    // busy holds until the RAM has been seen ready
    if (rst_seen && (rst || !ram_ready)) begin
      if (busy !== 1'b1 || data_out_valid !== 1'b0 || ram_cmd_en !== 1'b0) begin
        err_cnt++;
        $display("error at %0t: busy low or an output active before RAM ready", $time);
      end
    end
    if (!rst && ram_busy === 1'b0) begin
      ram_ready = 1'b1;
    end
    if (rst_seen && !rst) begin
      if (data_out_valid) begin
        if (exp_q.size() == 0) begin
          err_cnt++;
          $display("error at %0t: data_out_valid with no read pending", $time);
        end else begin
          exp = exp_q.pop_front();
          if (data_out !== exp) begin
            err_cnt++;
            $display("error at %0t: data_out %h, expected %h", $time, data_out, exp);
          end
        end
      end
      // a hit answers on the very next cycle
      if (due && !data_out_valid) begin
        err_cnt++;
        $display("error at %0t: hit read result missing on the next cycle", $time);
      end
      if (due && busy) begin
        err_cnt++;
        $display("error at %0t: busy raised after a hit read", $time);
      end
      if (ram_cmd_en) begin
        // write bursts carry whole beats
        if (ram_cmd == burst_ram_pkg::write && ram_data_mask !== '1) begin
          err_cnt++;
          $display("error at %0t: ram_data_mask %h on a write, expected all ones", $time,
                   ram_data_mask);
        end
        if (cmd_q.size() == 0) begin
          err_cnt++;
          $display("error at %0t: unexpected RAM command at %h", $time, ram_addr);
        end else begin
          cmd = cmd_q.pop_front();
          if ({ram_cmd == burst_ram_pkg::write, ram_addr} !== cmd) begin
            err_cnt++;
            $display("error at %0t: RAM command %0d at %h, expected %0d at %h", $time,
                     ram_cmd, ram_addr, cmd[`DC_RAM_DEPTH_W], cmd[`DC_RAM_DEPTH_W-1:0]);
          end
        end
      end
      // request accepted at the coming rising edge
      if (enable === 1'b1 && busy === 1'b0) begin
        line = address[`DC_ALIGN_W + `DC_WORD_IX_W +: `DC_LINE_IX_W];
        tag = address[`DC_ADDR_W-1 -: `DC_TAG_W];
        w = int'((address >> `DC_ALIGN_W) % model_words);
        hit = valid_m[line] && (tag_m[line] == tag);
        if (!hit) begin
          // dirty victim goes back before the refill
          if (valid_m[line] && dirty_m[line]) begin
            cmd_q.push_back({1'b1, line_beat(tag_m[line], line)});
          end
          cmd_q.push_back({1'b0, line_beat(tag, line)});
          valid_m[line] = 1'b1;
          dirty_m[line] = 1'b0;
          tag_m[line] = tag;
        end
        if (write_enable_bytes == '0) begin
          exp_q.push_back(model[w]);
          hit_due = hit;
        end else begin
          for (int b = 0; b < `DC_WORD_W / 8; b++) begin
            if (write_enable_bytes[b]) begin
              model[w][b*8 +: 8] = data_in[b*8 +: 8];
            end
          end
          dirty_m[line] = 1'b1;
        end
      end
    end
    pend_cnt = exp_q.size() + cmd_q.size();
  end

endmodule

/* tb_data_cache.sv */
//##################################################
// data cache testbench with a burst RAM model
// requests stay word aligned and below 2 KB
//##################################################
`timescale 1ns/1ps
`include "dcache_params.svh"

module tb_data_cache;

  localparam int seed_init = 41;
  localparam int ram_beats = 1 << `DC_RAM_DEPTH_W;
  localparam int n_random = 400;
  localparam int busy_limit = 200;

  logic clk;
  logic rst;
  logic enable;
  dcache_pkg::addr_t address;
  dcache_pkg::byte_en_t write_enable_bytes;
  dcache_pkg::word_t data_in;
  dcache_pkg::word_t data_out;
  logic data_out_valid;
  logic busy;
  burst_ram_pkg::ram_cmd_t ram_cmd;
  logic ram_cmd_en;
  burst_ram_pkg::ram_addr_t ram_addr;
  burst_ram_pkg::beat_t ram_wr_data;
  burst_ram_pkg::beat_mask_t ram_data_mask;
  burst_ram_pkg::beat_t ram_rd_data;
  logic ram_rd_data_valid;
  logic ram_busy;

  burst_ram_pkg::beat_t mem [ram_beats];
  integer seed;
  int timeouts = 0;
  logic aborted = 1'b0;
  int check_errors;
  int pending;

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  data_cache dut0 (
    .clk(clk), .rst(rst),
    .enable(enable), .address(address),
    .write_enable_bytes(write_enable_bytes), .data_in(data_in),
    .data_out(data_out), .data_out_valid(data_out_valid), .busy(busy),
    .ram_cmd(ram_cmd), .ram_cmd_en(ram_cmd_en), .ram_addr(ram_addr),
    .ram_wr_data(ram_wr_data), .ram_data_mask(ram_data_mask),
    .ram_rd_data(ram_rd_data), .ram_rd_data_valid(ram_rd_data_valid),
    .ram_busy(ram_busy)
  );

  dcache_checker #(.preload_seed(seed_init)) chk0 (
    .clk(clk), .rst(rst),
    .enable(enable), .address(address),
    .write_enable_bytes(write_enable_bytes), .data_in(data_in),
    .data_out(data_out), .data_out_valid(data_out_valid), .busy(busy),
    .ram_cmd(ram_cmd), .ram_cmd_en(ram_cmd_en), .ram_addr(ram_addr),
    .ram_data_mask(ram_data_mask),
    .ram_busy(ram_busy),
    .errors(check_errors), .pending(pending)
  );

  // burst RAM model acting 1 ns after each rising edge
  initial begin : ram_model
    int rd_left;
    int rd_wait;
    int wr_left;
    burst_ram_pkg::ram_addr_t rd_base;
    burst_ram_pkg::ram_addr_t wr_base;
    rd_left = 0;
    rd_wait = 0;
    wr_left = 0;
    rd_base = '0;
    wr_base = '0;
    ram_rd_data = '0;
    ram_rd_data_valid = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      ram_rd_data_valid = 1'b0;
      if (rd_left > 0) begin
        if (rd_wait > 0) begin
          rd_wait--;
        end else begin
          ram_rd_data = mem[rd_base + burst_ram_pkg::ram_addr_t'(`DC_BEATS - rd_left)];
          ram_rd_data_valid = 1'b1;
          rd_left--;
        end
      end
      // beats 1 to 3 of a write follow the command
      if (wr_left > 0) begin
        mem[wr_base + burst_ram_pkg::ram_addr_t'(`DC_BEATS - wr_left)] = ram_wr_data;
        wr_left--;
      end
      if (ram_cmd_en === 1'b1) begin
        if (ram_cmd == burst_ram_pkg::write) begin
          mem[ram_addr] = ram_wr_data;
          wr_base = ram_addr;
          wr_left = `DC_BEATS - 1;
        end else begin
          rd_base = ram_addr;
          rd_wait = $random(seed) & 3;
          rd_left = `DC_BEATS;
        end
      end
    end
  end

  // called 1 ns after a rising edge
  task automatic wait_not_busy();
    int n;
    n = 0;
    while (busy !== 1'b0 && n < busy_limit && !aborted) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (busy !== 1'b0 && !aborted) begin
      $display("timeout: busy stayed high for %0d cycles", busy_limit);
      timeouts++;
      aborted = 1'b1;
    end
  endtask

  // one request held until its accepting edge
  task automatic send_request(input dcache_pkg::addr_t a, input dcache_pkg::byte_en_t be,
                              input dcache_pkg::word_t d);
    if (!aborted) begin
      wait_not_busy();
    end
    if (!aborted) begin
      enable = 1'b1;
      address = a;
      write_enable_bytes = be;
      data_in = d;
      @(posedge clk);
      #1;
      enable = 1'b0;
    end
  endtask

  initial begin
    integer hi;
    integer lo;
    integer r;
    integer ra;
    dcache_pkg::addr_t a;
    dcache_pkg::addr_t last;
    dcache_pkg::byte_en_t be;
    int n;
    // RAM preload that the checker repeats
    seed = seed_init;
    for (int i = 0; i < ram_beats; i++) begin
      hi = $random(seed);
      lo = $random(seed);
      mem[i] = {hi, lo};
    end
    rst = 1'b1;
    enable = 1'b0;
    address = '0;
    write_enable_bytes = '0;
    data_in = '0;
    ram_busy = 1'b1;

    repeat (8) @(posedge clk);
    #1;
    rst = 1'b0;
    repeat (3) @(posedge clk);
    #1;
    ram_busy = 1'b0;
    wait_not_busy();

    // write miss then a conflicting read that evicts the dirty line
    a = 32'h0000_0104;
    send_request(a, 4'b0101, 32'ha5a5_5a5a);
    send_request(32'h0000_0504, 4'b0000, 32'h0);
    send_request(a, 4'b0000, 32'h0);
    // reads of the resident line on consecutive cycles
    send_request(a, 4'b0000, 32'h0);
    send_request(a + 4, 4'b0000, 32'h0);
    send_request(a + 8, 4'b0000, 32'h0);
    send_request(a + 24, 4'b0000, 32'h0);
    // write hit and read back
    send_request(a + 8, 4'b1000, 32'h3c00_0000);
    send_request(a + 8, 4'b0000, 32'h0);

    // random mix staying inside the last line half the time
    last = a;
    for (int i = 0; i < n_random; i++) begin
      r = $random(seed);
      ra = $random(seed);
      if (r[1]) begin
        a = {last[31:5], ra[4:2], 2'b00};
      end else begin
        a = {21'd0, ra[10:2], 2'b00};
      end
      if (r[0]) begin
        be = '0;
      end else begin
        be = r[7:4];
        if (be == '0) begin
          be = 4'hf;
        end
      end
      send_request(a, be, $random(seed));
      last = a;
    end

    wait_not_busy();
    n = 0;
    while (pending != 0 && n < busy_limit) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (pending != 0) begin
      $display("timeout: %0d read results or RAM commands never arrived", pending);
      timeouts++;
    end

    $display("errors: %0d failed checks, %0d timeouts", check_errors, timeouts);
    if (check_errors == 0 && timeouts == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

/* data_cache.f */
+incdir+.
dcache_pkg.sv
burst_ram_pkg.sv
line_store_if.sv
line_store.sv
dcache_ctrl.sv
data_cache.sv
dcache_checker.sv
tb_data_cache.sv

/* run.sh */
#!/bin/sh
# build and run the data cache testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_data_cache \
  -f data_cache.f > build.log 2>&1 &&
  ./obj_dir/Vtb_data_cache > sim.log 2>&1 ||
  { echo "build or simulation error, see build.log and sim.log"; exit 1; }

grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } ||
  { echo "PASS"; exit 0; }
